//--- pcie_stream_pkg.sv
// PCIe stream types
package pcie_stream_pkg;

  // Stream widths
  localparam int DATA_WIDTH    = 32;
  localparam int KEEP_WIDTH    = DATA_WIDTH / 8;
  localparam int BAR_HIT_WIDTH = 7;

  // One received or transmitted data word
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Byte enables, one bit per byte of data_t
  typedef logic [KEEP_WIDTH-1:0] keep_t;

  // One bit per BAR, as reported by the core with each received word
  typedef logic [BAR_HIT_WIDTH-1:0] bar_hit_t;

  // Bit positions in bar_hit_t that select a channel
  // Control has priority when both bits are set
  typedef enum logic [2:0] {
    BAR_CONTROL = 3'd0,
    BAR_DATA    = 3'd1
  } bar_sel_e;

  // Buffered unit, 37 bits wide
  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
  } stream_word_t;

  localparam int STREAM_WORD_WIDTH = $bits(stream_word_t);

endpackage

//--- pcie_irq_pkg.sv
// Interrupt requester types
package pcie_irq_pkg;

  localparam int IRQ_CHANNEL_WIDTH = 8;

  // Requester states
  // IRQ_SEND holds the request until the core grants it
  typedef enum logic {
    IRQ_IDLE = 1'b0,
    IRQ_SEND = 1'b1
  } irq_state_e;

  // Channel number carried with the request
  typedef logic [IRQ_CHANNEL_WIDTH-1:0] irq_channel_t;

endpackage

//--- stream_if.sv
// Valid/ready word stream
`timescale 1ns/1ps

interface stream_if
  import pcie_stream_pkg::*;
();

  data_t data;
  keep_t keep;
  logic  last;
  logic  valid;
  logic  ready;

  // A word moves on every edge where valid and ready are both high
  modport source (
    output data,
    output keep,
    output last,
    output valid,
    input  ready
  );

  modport sink (
    input  data,
    input  keep,
    input  last,
    input  valid,
    output ready
  );

endinterface

//--- bar_channel.sv
// Per-BAR ingress and egress buffers
`timescale 1ns/1ps

module bar_channel
  import pcie_stream_pkg::*;
#(
  parameter int ADDR_WIDTH = 4
) (
  input  logic          clk_62p5,
  input  logic          pcie_reset,

  stream_if.sink        rx_in,
  stream_if.source      tx_out,

  // User read side of the ingress buffer
  input  logic          i_in_rd_stb,
  output logic          o_in_valid,
  output stream_word_t  o_in_word,

  // User write side of the egress buffer
  input  logic          i_out_wr_stb,
  input  stream_word_t  i_out_word,
  output logic          o_out_full
);

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam logic [ADDR_WIDTH:0] FULL_COUNT = {1'b1, {ADDR_WIDTH{1'b0}}};

  // Ingress buffer, stream in, user out
  stream_word_t            in_mem [0:DEPTH-1];
  logic [ADDR_WIDTH-1:0]   in_wr_ptr;
  logic [ADDR_WIDTH-1:0]   in_rd_ptr;
  logic [ADDR_WIDTH:0]     in_count;
  logic                    in_push;
  logic                    in_pop;
  stream_word_t            rx_word;

  // Egress buffer, user in, stream out
  stream_word_t            out_mem [0:DEPTH-1];
  logic [ADDR_WIDTH-1:0]   out_wr_ptr;
  logic [ADDR_WIDTH-1:0]   out_rd_ptr;
  logic [ADDR_WIDTH:0]     out_count;
  logic [ADDR_WIDTH:0]     out_count_next;
  logic                    out_push;
  logic                    out_pop;
  logic                    out_valid_q;
  stream_word_t            out_head;

  assign rx_word     = '{data: rx_in.data, keep: rx_in.keep, last: rx_in.last};
  assign rx_in.ready = (in_count != FULL_COUNT);
  assign in_push     = rx_in.valid && rx_in.ready;
  assign o_in_valid  = (in_count != '0);
  assign in_pop      = i_in_rd_stb && o_in_valid;
  // Show-ahead, head word is always on the read port
  assign o_in_word   = in_mem[in_rd_ptr];

  always_ff @(posedge clk_62p5) begin
    if (in_push) begin
      in_mem[in_wr_ptr] <= rx_word;
    end
  end

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      in_wr_ptr <= '0;
      in_rd_ptr <= '0;
      in_count  <= '0;
    end else begin
      if (in_push) begin
        in_wr_ptr <= in_wr_ptr + 1'b1;
      end
      if (in_pop) begin
        in_rd_ptr <= in_rd_ptr + 1'b1;
      end
      if (in_push && !in_pop) begin
        in_count <= in_count + 1'b1;
      end else if (in_pop && !in_push) begin
        in_count <= in_count - 1'b1;
      end
    end
  end

  assign o_out_full = (out_count == FULL_COUNT);
  // Writes while full are dropped
  assign out_push   = i_out_wr_stb && !o_out_full;
  assign out_pop    = out_valid_q && tx_out.ready;
  assign out_head   = out_mem[out_rd_ptr];

  assign tx_out.data  = out_head.data;
  assign tx_out.keep  = out_head.keep;
  assign tx_out.last  = out_head.last;
  assign tx_out.valid = out_valid_q;

  always_comb begin
    out_count_next = out_count;
    if (out_push && !out_pop) begin
      out_count_next = out_count + 1'b1;
    end else if (out_pop && !out_push) begin
      out_count_next = out_count - 1'b1;
    end
  end

  always_ff @(posedge clk_62p5) begin
    if (out_push) begin
      out_mem[out_wr_ptr] <= i_out_word;
    end
  end

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      out_wr_ptr  <= '0;
      out_rd_ptr  <= '0;
      out_count   <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (out_push) begin
        out_wr_ptr <= out_wr_ptr + 1'b1;
      end
      if (out_pop) begin
        out_rd_ptr <= out_rd_ptr + 1'b1;
      end
      out_count   <= out_count_next;
      // Valid tracks a non-empty buffer, one edge after the write
      out_valid_q <= (out_count_next != '0);
    end
  end

endmodule

//--- bar_router.sv
// BAR-hit stream router
`timescale 1ns/1ps

module bar_router
  import pcie_stream_pkg::*;
(
  input  bar_hit_t   i_bar_hit,

  // Receive stream from the core
  input  data_t      i_rx_data,
  input  keep_t      i_rx_keep,
  input  logic       i_rx_last,
  input  logic       i_rx_valid,
  output logic       o_rx_ready,

  // Transmit stream to the core
  output data_t      o_tx_data,
  output keep_t      o_tx_keep,
  output logic       o_tx_last,
  output logic       o_tx_valid,
  input  logic       i_tx_ready,

  // Channel side
  stream_if.source   ctl_rx,
  stream_if.source   dat_rx,
  stream_if.sink     ctl_tx,
  stream_if.sink     dat_tx
);

  logic sel_ctl;
  logic sel_dat;

  // Control wins when both bits are set
  assign sel_ctl = i_bar_hit[BAR_CONTROL];
  assign sel_dat = i_bar_hit[BAR_DATA] && !sel_ctl;

  // Payload goes to both, valid only to the selected channel
  assign ctl_rx.data  = i_rx_data;
  assign ctl_rx.keep  = i_rx_keep;
  assign ctl_rx.last  = i_rx_last;
  assign ctl_rx.valid = i_rx_valid && sel_ctl;

  assign dat_rx.data  = i_rx_data;
  assign dat_rx.keep  = i_rx_keep;
  assign dat_rx.last  = i_rx_last;
  assign dat_rx.valid = i_rx_valid && sel_dat;

  // No channel hit leaves the receive stream stalled
  assign o_rx_ready = sel_ctl ? ctl_rx.ready :
                      sel_dat ? dat_rx.ready : 1'b0;

  assign ctl_tx.ready = i_tx_ready && sel_ctl;
  assign dat_tx.ready = i_tx_ready && sel_dat;

  assign o_tx_data  = sel_ctl ? ctl_tx.data :
                      sel_dat ? dat_tx.data : '0;
  assign o_tx_keep  = sel_ctl ? ctl_tx.keep :
                      sel_dat ? dat_tx.keep : '0;
  assign o_tx_last  = sel_ctl ? ctl_tx.last :
                      sel_dat ? dat_tx.last : 1'b0;
  assign o_tx_valid = sel_ctl ? ctl_tx.valid :
                      sel_dat ? dat_tx.valid : 1'b0;

endmodule

//--- irq_requester.sv
// Configuration interrupt requester
`timescale 1ns/1ps

module irq_requester
  import pcie_irq_pkg::*;
(
  input  logic          clk_62p5,
  input  logic          pcie_reset,

  input  logic          i_interrupt_stb,
  input  irq_channel_t  i_interrupt_channel,

  input  logic          i_cfg_interrupt_rdy,
  output logic          o_cfg_interrupt,
  output irq_channel_t  o_cfg_interrupt_di
);

  irq_state_e   irq_state;
  irq_channel_t channel_q;

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      irq_state <= IRQ_IDLE;
    end else begin
      case (irq_state)
        IRQ_IDLE: begin
          if (i_interrupt_stb) begin
            irq_state <= IRQ_SEND;
          end
        end
        IRQ_SEND: begin
          // Hold until the core takes it, strobes here are dropped
          if (i_cfg_interrupt_rdy) begin
            irq_state <= IRQ_IDLE;
          end
        end
        default: irq_state <= IRQ_IDLE;
      endcase
    end
  end

  // Channel is captured only when a new request starts
  always_ff @(posedge clk_62p5) begin
    if (irq_state == IRQ_IDLE && i_interrupt_stb) begin
      channel_q <= i_interrupt_channel;
    end
  end

  assign o_cfg_interrupt    = (irq_state == IRQ_SEND);
  assign o_cfg_interrupt_di = channel_q;

endmodule

//--- pcie_user_bridge.sv
// PCIe endpoint user bridge
`timescale 1ns/1ps

module pcie_user_bridge
  import pcie_stream_pkg::*;
  import pcie_irq_pkg::*;
#(
  parameter int CONTROL_ADDR_WIDTH = 4,
  parameter int DATA_ADDR_WIDTH    = 6
) (
  input  logic          clk_62p5,
  input  logic          pcie_reset,

  input  bar_hit_t      i_bar_hit,

  // Receive stream
  input  data_t         i_rx_data,
  input  keep_t         i_rx_keep,
  input  logic          i_rx_last,
  input  logic          i_rx_valid,
  output logic          o_rx_ready,

  // Transmit stream
  output data_t         o_tx_data,
  output keep_t         o_tx_keep,
  output logic          o_tx_last,
  output logic          o_tx_valid,
  input  logic          i_tx_ready,

  // Interrupt
  input  logic          i_interrupt_stb,
  input  irq_channel_t  i_interrupt_channel,
  input  logic          i_cfg_interrupt_rdy,
  output logic          o_cfg_interrupt,
  output irq_channel_t  o_cfg_interrupt_di,

  // Control channel, BAR 0
  input  logic          i_cmd_in_rd_stb,
  output logic          o_cmd_in_valid,
  output data_t         o_cmd_in_data,
  output keep_t         o_cmd_in_keep,
  output logic          o_cmd_in_last,
  input  logic          i_cmd_out_wr_stb,
  input  data_t         i_cmd_out_data,
  input  keep_t         i_cmd_out_keep,
  input  logic          i_cmd_out_last,
  output logic          o_cmd_out_full,

  // Data channel, BAR 1
  input  logic          i_data_in_rd_stb,
  output logic          o_data_in_valid,
  output data_t         o_data_in_data,
  output keep_t         o_data_in_keep,
  output logic          o_data_in_last,
  input  logic          i_data_out_wr_stb,
  input  data_t         i_data_out_data,
  input  keep_t         i_data_out_keep,
  input  logic          i_data_out_last,
  output logic          o_data_out_full
);

  stream_if ctl_rx_if ();
  stream_if dat_rx_if ();
  stream_if ctl_tx_if ();
  stream_if dat_tx_if ();

  stream_word_t cmd_in_word;
  stream_word_t cmd_out_word;
  stream_word_t data_in_word;
  stream_word_t data_out_word;

  assign cmd_out_word  = '{data: i_cmd_out_data, keep: i_cmd_out_keep, last: i_cmd_out_last};
  assign data_out_word = '{data: i_data_out_data, keep: i_data_out_keep,
                           last: i_data_out_last};

  assign o_cmd_in_data  = cmd_in_word.data;
  assign o_cmd_in_keep  = cmd_in_word.keep;
  assign o_cmd_in_last  = cmd_in_word.last;
  assign o_data_in_data = data_in_word.data;
  assign o_data_in_keep = data_in_word.keep;
  assign o_data_in_last = data_in_word.last;

  bar_channel #(
    .ADDR_WIDTH (CONTROL_ADDR_WIDTH)
  ) u_control (
    .clk_62p5     (clk_62p5),
    .pcie_reset   (pcie_reset),
    .rx_in        (ctl_rx_if.sink),
    .tx_out       (ctl_tx_if.source),
    .i_in_rd_stb  (i_cmd_in_rd_stb),
    .o_in_valid   (o_cmd_in_valid),
    .o_in_word    (cmd_in_word),
    .i_out_wr_stb (i_cmd_out_wr_stb),
    .i_out_word   (cmd_out_word),
    .o_out_full   (o_cmd_out_full)
  );

  bar_channel #(
    .ADDR_WIDTH (DATA_ADDR_WIDTH)
  ) u_data (
    .clk_62p5     (clk_62p5),
    .pcie_reset   (pcie_reset),
    .rx_in        (dat_rx_if.sink),
    .tx_out       (dat_tx_if.source),
    .i_in_rd_stb  (i_data_in_rd_stb),
    .o_in_valid   (o_data_in_valid),
    .o_in_word    (data_in_word),
    .i_out_wr_stb (i_data_out_wr_stb),
    .i_out_word   (data_out_word),
    .o_out_full   (o_data_out_full)
  );

  bar_router u_router (
    .i_bar_hit  (i_bar_hit),
    .i_rx_data  (i_rx_data),
    .i_rx_keep  (i_rx_keep),
    .i_rx_last  (i_rx_last),
    .i_rx_valid (i_rx_valid),
    .o_rx_ready (o_rx_ready),
    .o_tx_data  (o_tx_data),
    .o_tx_keep  (o_tx_keep),
    .o_tx_last  (o_tx_last),
    .o_tx_valid (o_tx_valid),
    .i_tx_ready (i_tx_ready),
    .ctl_rx     (ctl_rx_if.source),
    .dat_rx     (dat_rx_if.source),
    .ctl_tx     (ctl_tx_if.sink),
    .dat_tx     (dat_tx_if.sink)
  );

  irq_requester u_irq (
    .clk_62p5            (clk_62p5),
    .pcie_reset          (pcie_reset),
    .i_interrupt_stb     (i_interrupt_stb),
    .i_interrupt_channel (i_interrupt_channel),
    .i_cfg_interrupt_rdy (i_cfg_interrupt_rdy),
    .o_cfg_interrupt     (o_cfg_interrupt),
    .o_cfg_interrupt_di  (o_cfg_interrupt_di)
  );

endmodule

//--- pcie_user_bridge_assert.sv
// Bridge handshake assertions
`timescale 1ns/1ps

module pcie_user_bridge_assert
  import pcie_stream_pkg::*;
(
  input logic  clk_62p5,
  input logic  pcie_reset,
  input logic  o_tx_valid,
  input logic  i_tx_ready,
  input data_t o_tx_data,
  input keep_t o_tx_keep,
  input logic  o_tx_last,
  input logic  o_cfg_interrupt,
  input logic  i_cfg_interrupt_rdy,
  input logic  o_cmd_in_valid,
  input logic  o_data_in_valid
);

  // Stalled transmit word is held
  tx_hold_a : assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable({o_tx_data, o_tx_keep, o_tx_last}))
    else $error("transmit word changed while stalled");

  // Request held until granted
  irq_hold_a : assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    o_cfg_interrupt && !i_cfg_interrupt_rdy |=> o_cfg_interrupt)
    else $error("interrupt request dropped before the grant");

  rst_empty_a : assert property (@(posedge clk_62p5)
    pcie_reset |=> !o_cmd_in_valid && !o_data_in_valid)
    else $error("read port valid after reset");

endmodule

//--- tb_pcie_user_bridge.sv
// User bridge testbench
`timescale 1ns/1ps

module tb_pcie_user_bridge
  import pcie_stream_pkg::*;
  import pcie_irq_pkg::*;
();

  localparam int RESET_CYCLES   = 16;
  localparam int CMD_DEPTH      = 16;
  localparam int DATA_DEPTH     = 64;
  localparam int N_CTL_IN       = 40;
  localparam int N_MIX_IN       = 50;
  localparam int N_EGRESS       = 12;
  localparam int N_BP_DATA      = 40;
  localparam int N_BP_CMD       = CMD_DEPTH + 1;
  localparam int IRQ_ROUNDS     = 4;
  localparam int TOTAL_WORDS    = N_CTL_IN + N_MIX_IN + 2 * N_EGRESS + N_BP_DATA + N_BP_CMD
                                  + CMD_DEPTH + 1 + IRQ_ROUNDS;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20 + RESET_CYCLES;
  localparam int POOL_SIZE      = 1024;

  typedef enum int {CH_NONE, CH_CTL, CH_DAT} channel_e;

  logic         clk_62p5 = 1'b0;
  logic         pcie_reset;
  bar_hit_t     i_bar_hit;
  data_t        i_rx_data, o_tx_data, o_cmd_in_data, i_cmd_out_data;
  data_t        o_data_in_data, i_data_out_data;
  keep_t        i_rx_keep, o_tx_keep, o_cmd_in_keep, i_cmd_out_keep;
  keep_t        o_data_in_keep, i_data_out_keep;
  logic         i_rx_last, i_rx_valid, o_rx_ready;
  logic         o_tx_last, o_tx_valid, i_tx_ready;
  logic         i_interrupt_stb, i_cfg_interrupt_rdy, o_cfg_interrupt;
  irq_channel_t i_interrupt_channel, o_cfg_interrupt_di;
  logic         i_cmd_in_rd_stb, o_cmd_in_valid, o_cmd_in_last;
  logic         i_cmd_out_wr_stb, i_cmd_out_last, o_cmd_out_full;
  logic         i_data_in_rd_stb, o_data_in_valid, o_data_in_last;
  logic         i_data_out_wr_stb, i_data_out_last, o_data_out_full;

  int           seed = 39;
  logic [31:0]  pool [0:POOL_SIZE-1];
  int           pool_idx = 0;
  int           error_count = 0;
  int           errors_at_start = 0;
  int           tests_run = 0;
  int           tests_failed = 0;
  int           words_checked = 0;
  bit           rd_random_en = 1'b0;
  bit           tx_random_en = 1'b0;
  bit           tx_ready_level = 1'b0;
  int           cmd_pulse_req = 0;
  int           cmd_pulse_done = 0;

  // Expected words per channel and direction
  stream_word_t cmd_in_q[$];
  stream_word_t data_in_q[$];
  stream_word_t cmd_out_q[$];
  stream_word_t data_out_q[$];

  always #4 clk_62p5 = ~clk_62p5;

  pcie_user_bridge #(
    .CONTROL_ADDR_WIDTH (4),
    .DATA_ADDR_WIDTH    (6)
  ) dut (.*);

  bind pcie_user_bridge pcie_user_bridge_assert u_assert (
    .clk_62p5            (clk_62p5),
    .pcie_reset          (pcie_reset),
    .o_tx_valid          (o_tx_valid),
    .i_tx_ready          (i_tx_ready),
    .o_tx_data           (o_tx_data),
    .o_tx_keep           (o_tx_keep),
    .o_tx_last           (o_tx_last),
    .o_cfg_interrupt     (o_cfg_interrupt),
    .i_cfg_interrupt_rdy (i_cfg_interrupt_rdy),
    .o_cmd_in_valid      (o_cmd_in_valid),
    .o_data_in_valid     (o_data_in_valid)
  );

  // Reference model, control wins when both BAR bits are set
  function automatic channel_e expected_channel(input bar_hit_t hit);
    if (hit[BAR_CONTROL]) begin
      return CH_CTL;
    end else if (hit[BAR_DATA]) begin
      return CH_DAT;
    end
    return CH_NONE;
  endfunction

  function automatic logic [31:0] next_rand();
    pool_idx = (pool_idx + 1) % POOL_SIZE;
    return pool[pool_idx];
  endfunction

  function automatic stream_word_t random_word();
    logic [31:0]  r;
    stream_word_t w;
    r = next_rand();
    w.keep = r[3:0];
    w.last = r[4];
    w.data = next_rand();
    return w;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic compare_word(input string base, input stream_word_t exp,
                              input stream_word_t got);
    check_value({base, "_data"}, 64'(got.data), 64'(exp.data));
    check_value({base, "_keep"}, 64'(got.keep), 64'(exp.keep));
    check_value({base, "_last"}, 64'(got.last), 64'(exp.last));
    words_checked++;
  endtask

  task automatic check_read(input channel_e ch, input stream_word_t got);
    if (ch == CH_CTL && cmd_in_q.size() != 0) begin
      compare_word("o_cmd_in", cmd_in_q.pop_front(), got);
    end else if (ch == CH_DAT && data_in_q.size() != 0) begin
      compare_word("o_data_in", data_in_q.pop_front(), got);
    end else begin
      report_error("a user read port returned a word that was never sent to it");
    end
  endtask

  task automatic check_tx(input channel_e ch, input stream_word_t got);
    if (ch == CH_CTL && cmd_out_q.size() != 0) begin
      compare_word("o_tx", cmd_out_q.pop_front(), got);
    end else if (ch == CH_DAT && data_out_q.size() != 0) begin
      compare_word("o_tx", data_out_q.pop_front(), got);
    end else begin
      report_error("the transmit stream sent a word the selected channel never held");
    end
  endtask

  // Every handshake is compared with the head of its queue
  always @(posedge clk_62p5) begin
    if (!pcie_reset) begin
      if (i_cmd_in_rd_stb && o_cmd_in_valid) begin
        check_read(CH_CTL, {o_cmd_in_data, o_cmd_in_keep, o_cmd_in_last});
      end
      if (i_data_in_rd_stb && o_data_in_valid) begin
        check_read(CH_DAT, {o_data_in_data, o_data_in_keep, o_data_in_last});
      end
      if (o_tx_valid && i_tx_ready) begin
        check_tx(expected_channel(i_bar_hit), {o_tx_data, o_tx_keep, o_tx_last});
      end
    end
  end

  // Read strobes and transmit ready, random or fixed
  initial begin
    logic [31:0] r;
    i_cmd_in_rd_stb  = 1'b0;
    i_data_in_rd_stb = 1'b0;
    i_tx_ready       = 1'b0;
    forever begin
      @(negedge clk_62p5);
      r = $random(seed);
      i_cmd_in_rd_stb  = (rd_random_en && r[0]) || (cmd_pulse_req != cmd_pulse_done);
      cmd_pulse_done   = cmd_pulse_req;
      i_data_in_rd_stb = rd_random_en && r[1];
      i_tx_ready       = tx_random_en ? r[2] : tx_ready_level;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_62p5);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  task automatic set_modes(input bit rd_random, input bit tx_random, input bit tx_level);
    @(posedge clk_62p5);
    rd_random_en   = rd_random;
    tx_random_en   = tx_random;
    tx_ready_level = tx_level;
    @(negedge clk_62p5);
  endtask

  // Starts and ends on a falling edge
  task automatic send_rx(input bar_hit_t hit, input stream_word_t w);
    i_bar_hit = hit;
    {i_rx_data, i_rx_keep, i_rx_last} = w;
    i_rx_valid = 1'b1;
    @(posedge clk_62p5);
    while (!o_rx_ready) begin
      @(posedge clk_62p5);
    end
    if (expected_channel(hit) == CH_CTL) begin
      cmd_in_q.push_back(w);
    end else begin
      data_in_q.push_back(w);
    end
    @(negedge clk_62p5);
    i_rx_valid = 1'b0;
  endtask

  // Egress buffer holds every written word not yet sent
  task automatic write_out(input channel_e ch, input stream_word_t w);
    bit full_exp;
    if (ch == CH_CTL) begin
      full_exp = (cmd_out_q.size() >= CMD_DEPTH);
      check_value("o_cmd_out_full", 64'(o_cmd_out_full), 64'(full_exp));
      i_cmd_out_wr_stb = 1'b1;
      {i_cmd_out_data, i_cmd_out_keep, i_cmd_out_last} = w;
    end else begin
      full_exp = (data_out_q.size() >= DATA_DEPTH);
      check_value("o_data_out_full", 64'(o_data_out_full), 64'(full_exp));
      i_data_out_wr_stb = 1'b1;
      {i_data_out_data, i_data_out_keep, i_data_out_last} = w;
    end
    @(posedge clk_62p5);
    // A write to a full channel is dropped
    if (!full_exp) begin
      if (ch == CH_CTL) begin
        cmd_out_q.push_back(w);
      end else begin
        data_out_q.push_back(w);
      end
    end
    @(negedge clk_62p5);
    i_cmd_out_wr_stb  = 1'b0;
    i_data_out_wr_stb = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_count - errors_at_start;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %0d %s: %s, %0d errors", tests_run, name, (errs == 0) ? "ok" : "FAILED", errs);
    errors_at_start = error_count;
  endtask

  initial begin
    logic [31:0]  r;
    int           i;
    int           k;
    int           hold;
    stream_word_t w;
    irq_channel_t ch;
    for (i = 0; i < POOL_SIZE; i++) begin
      pool[i] = $random(seed);
    end
    pcie_reset = 1'b1;
    i_bar_hit = '0;
    {i_rx_data, i_rx_keep, i_rx_last, i_rx_valid} = '0;
    {i_cmd_out_wr_stb, i_cmd_out_data, i_cmd_out_keep, i_cmd_out_last} = '0;
    {i_data_out_wr_stb, i_data_out_data, i_data_out_keep, i_data_out_last} = '0;
    {i_interrupt_stb, i_interrupt_channel, i_cfg_interrupt_rdy} = '0;
    repeat (RESET_CYCLES) @(posedge clk_62p5);
    @(negedge clk_62p5);
    pcie_reset = 1'b0;

    set_modes(1'b1, 1'b0, 1'b0);
    for (i = 0; i < N_CTL_IN; i++) begin
      r = next_rand();
      send_rx({r[6:2], 2'b01}, random_word());
      if (r[8:7] == 2'b00) begin
        @(negedge clk_62p5);
      end
    end
    while (cmd_in_q.size() != 0) begin
      @(negedge clk_62p5);
    end
    check_value("o_data_in_valid", 64'(o_data_in_valid), 64'd0);
    finish_test("control ingress");

    // Data only, or both bits set so control takes it
    for (i = 0; i < N_MIX_IN; i++) begin
      r = next_rand();
      send_rx({r[6:2], r[0] ? 2'b11 : 2'b10}, random_word());
    end
    while (cmd_in_q.size() + data_in_q.size() != 0) begin
      @(negedge clk_62p5);
    end
    finish_test("data ingress with priority");

    i_bar_hit = '0;
    for (i = 0; i < N_EGRESS; i++) begin
      write_out(CH_CTL, random_word());
      write_out(CH_DAT, random_word());
    end
    i_bar_hit = 7'b0000010;
    set_modes(1'b1, 1'b0, 1'b1);
    while (data_out_q.size() != 0) begin
      @(negedge clk_62p5);
    end
    repeat (5) @(negedge clk_62p5);
    // Control still holds its words but is not selected
    check_value("o_tx_valid", 64'(o_tx_valid), 64'd0);
    i_bar_hit = 7'b0000001;
    while (cmd_out_q.size() != 0) begin
      @(negedge clk_62p5);
    end
    i_bar_hit = '0;
    finish_test("egress selection");

    // Control gets one write more than it holds
    set_modes(1'b1, 1'b0, 1'b0);
    for (i = 0; i < N_BP_DATA; i++) begin
      write_out(CH_DAT, random_word());
    end
    for (i = 0; i < N_BP_CMD; i++) begin
      write_out(CH_CTL, random_word());
    end
    i_bar_hit = 7'b0000010;
    set_modes(1'b1, 1'b1, 1'b0);
    while (data_out_q.size() != 0) begin
      @(negedge clk_62p5);
    end
    i_bar_hit = 7'b0000001;
    while (cmd_out_q.size() != 0) begin
      @(negedge clk_62p5);
    end
    repeat (4) @(negedge clk_62p5);
    i_bar_hit = '0;
    set_modes(1'b1, 1'b0, 1'b0);
    finish_test("transmit back-pressure");

    // Control channel left unread until it fills
    set_modes(1'b0, 1'b0, 1'b0);
    for (i = 0; i < CMD_DEPTH; i++) begin
      send_rx(7'b0000001, random_word());
    end
    w = random_word();
    i_bar_hit = 7'b0000001;
    {i_rx_data, i_rx_keep, i_rx_last} = w;
    i_rx_valid = 1'b1;
    repeat (8) begin
      @(posedge clk_62p5);
      check_value("o_rx_ready", 64'(o_rx_ready), 64'd0);
    end
    cmd_pulse_req++;
    @(posedge clk_62p5);
    while (!o_rx_ready) begin
      @(posedge clk_62p5);
    end
    cmd_in_q.push_back(w);
    @(negedge clk_62p5);
    i_rx_valid = 1'b0;
    @(posedge clk_62p5);
    check_value("o_rx_ready", 64'(o_rx_ready), 64'd0);
    @(negedge clk_62p5);
    set_modes(1'b1, 1'b0, 1'b0);
    while (cmd_in_q.size() != 0) begin
      @(negedge clk_62p5);
    end
    finish_test("ingress full");

    for (i = 0; i < IRQ_ROUNDS; i++) begin
      r = next_rand();
      ch = r[7:0];
      hold = 3 + int'(r[10:8]);
      i_interrupt_channel = ch;
      i_interrupt_stb = 1'b1;
      @(posedge clk_62p5);
      @(negedge clk_62p5);
      for (k = 0; k < hold; k++) begin
        check_value("o_cfg_interrupt", 64'(o_cfg_interrupt), 64'd1);
        check_value("o_cfg_interrupt_di", 64'(o_cfg_interrupt_di), 64'(ch));
        // Second strobe lands while the request is pending
        i_interrupt_stb = (k == 1);
        i_interrupt_channel = ch ^ 8'h5a;
        @(posedge clk_62p5);
        @(negedge clk_62p5);
      end
      i_interrupt_stb = 1'b0;
      check_value("o_cfg_interrupt", 64'(o_cfg_interrupt), 64'd1);
      i_cfg_interrupt_rdy = 1'b1;
      @(posedge clk_62p5);
      @(negedge clk_62p5);
      i_cfg_interrupt_rdy = 1'b0;
      repeat (2) begin
        check_value("o_cfg_interrupt", 64'(o_cfg_interrupt), 64'd0);
        @(posedge clk_62p5);
        @(negedge clk_62p5);
      end
    end
    finish_test("interrupt");

    $display("Tests run %0d, failed %0d, errors %0d, words checked %0d",
             tests_run, tests_failed, error_count, words_checked);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
pcie_stream_pkg.sv
pcie_irq_pkg.sv
stream_if.sv
bar_channel.sv
bar_router.sv
irq_requester.sv
pcie_user_bridge.sv
pcie_user_bridge_assert.sv
tb_pcie_user_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the user bridge testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_pcie_user_bridge -f filelist.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && echo "Run failed" && exit 1
grep -q "Simulation passed" sim.log || { echo "Run ended without a verdict"; exit 1; }
exit 0
